// File: include/rng_macros.svh
// Random byte source constants for counter size, bus widths, register map and priming depth
`ifndef RNG_MACROS_SVH
`define RNG_MACROS_SVH

// Width of the step counter that feeds the CRC hash
`define RNG_CNT_W 40

// Wishbone data width in bits
`define WB_DW 32

// Wishbone word address width in bits
`define WB_AW 4

// Register map in word addresses
// Seed register, write only
`define RNG_ADDR_SEED 4'd0
// Control register with skip count and read counter clear, write only
`define RNG_ADDR_CTRL 4'd1
// Random byte register, read only, every read consumes one value
`define RNG_ADDR_RAND 4'd2
// Read counter register, read only
`define RNG_ADDR_COUNT 4'd3

// Steps needed after a seed load to fill the hash and output registers
`define RNG_PRIME_STEPS 2

`endif

// File: rtl/rng_pkg.sv
// Generator types shared by the controller and the hash generator
`default_nettype none

`include "rng_macros.svh"

package rng_pkg;

  // Step counter word, the seed is zero-extended into it
  typedef logic [`RNG_CNT_W-1:0] rng_cnt_t;

  // CRC hash byte and mixed output byte
  typedef logic [7:0] rng_byte_t;

  // Command from the controller to the generator
  // Load has priority over step when both are set
  typedef struct packed {
    // Restart the sequence from seed and clear the pipeline
    logic load;
    // Seed value taken straight from the bus write word
    logic [`WB_DW-1:0] seed;
    // Advance counter, hash and output registers by one
    logic step;
  } rng_cmd_t;

endpackage

`default_nettype wire

// File: rtl/wb_pkg.sv
// Wishbone classic bus types and the decoded views of the write word
`default_nettype none

`include "rng_macros.svh"

package wb_pkg;

  // Master to slave signals of one classic transfer
  // All fields stay stable until ack or err
  typedef struct packed {
    logic cyc;
    logic stb;
    logic we;
    logic [`WB_AW-1:0] adr;
    logic [`WB_DW-1:0] dat;
  } wb_req_t;

  // Slave to master signals
  // Only one of ack and err is high, and only for a single cycle
  typedef struct packed {
    logic ack;
    logic err;
    logic [`WB_DW-1:0] dat;
  } wb_rsp_t;

  // Layout of the control register write word
  typedef struct packed {
    // Ignored on write
    logic [22:0] rsvd;
    // Set to zero the read counter
    logic clear_count;
    // Number of values to throw away, zero is allowed
    logic [7:0] skip;
  } wb_ctrl_t;

  // Write word as seen by the register decoder
  // The seed register takes the raw word, the control register the field view
  typedef union packed {
    logic [`WB_DW-1:0] raw;
    wb_ctrl_t ctrl;
  } wb_wdata_u;

endpackage

`default_nettype wire

// File: rtl/rng_hash_gen.sv
// Pseudo-random byte generator that hashes a step counter with an 8-bit CRC and a shift-xor-add mixer
`timescale 1ns/10ps
`default_nettype none

module rng_hash_gen (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire rng_pkg::rng_cmd_t cmd,
  output rng_pkg::rng_byte_t     rand_byte
);

  import rng_pkg::*;

  // One XOR tap mask over the counter for each CRC output bit
  // Bits 3 to 7 follow a shift-by-one pattern of the polynomial
  localparam rng_cnt_t crc_taps [8] = '{
    40'h8C_D0AD_51C1,
    40'h95_71F7_F243,
    40'hA6_3342_B547,
    40'h4C_6685_6A8E,
    40'h98_CD0A_D51C,
    40'h31_9A15_AA38,
    40'h63_342B_5470,
    40'hC6_6856_A8E0
  };

  rng_cnt_t  cnt_q;
  rng_byte_t crc_q;
  rng_byte_t out_q;
  rng_byte_t crc_d;

  // Mixing chain of xor-shift-right and add-shift-left stages
  // Everything is kept at eight bits so the left shifts drop their top bits
  function automatic rng_byte_t mix_byte(input rng_byte_t h);
    rng_byte_t m;
    m = h;
    m = m ^ (m >> 2);
    m = m + (m << 5);
    m = m ^ (m >> 3);
    m = m + (m << 4);
    m = m ^ (m >> 2);
    m = m ^ (m >> 4);
    return m;
  endfunction

  // Each hash bit is the parity of the counter bits picked by its mask
  always_comb begin
    for (int i = 0; i < $bits(rng_byte_t); i++) begin
      crc_d[i] = ^(cnt_q & crc_taps[i]);
    end
  end

  // Counter, hash and output registers move together, so the output trails
  // the counter by two steps
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Reset loads the default seed of one and leaves the pipeline unprimed
      cnt_q <= rng_cnt_t'(1);
      crc_q <= '0;
      out_q <= '0;
    end else if (cmd.load) begin
      cnt_q <= rng_cnt_t'(cmd.seed);
      crc_q <= '0;
      out_q <= '0;
    end else if (cmd.step) begin
      cnt_q <= cnt_q + rng_cnt_t'(1);
      crc_q <= crc_d;
      out_q <= mix_byte(crc_q);
    end
  end

  // The output register drives the port directly
  assign rand_byte = out_q;

endmodule

`default_nettype wire

// File: rtl/rng_step_timer.sv
// Down-counter of generator steps still owed for a seed or skip command
`timescale 1ns/10ps
`default_nettype none

module rng_step_timer (
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       start,
  input  wire logic [8:0] count,
  output logic            busy,
  output logic            done
);

  logic [8:0] cnt_q;
  logic       done_q;

  // Each busy cycle stands for exactly one step taken by the controller
  assign busy = (cnt_q != 9'd0);
  assign done = done_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q  <= '0;
      done_q <= 1'b0;
    end else begin
      // Pulse once the last owed step has been drawn
      // A zero count skips straight to the pulse
      done_q <= (start && (count == 9'd0)) || (busy && (cnt_q == 9'd1));
      if (start) begin
        cnt_q <= count;
      end else if (busy) begin
        cnt_q <= cnt_q - 9'd1;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/rng_ctrl_fsm.sv
// Wishbone slave FSM that decodes the registers, steps the generator and counts random reads
`timescale 1ns/10ps
`default_nettype none

`include "rng_macros.svh"

module rng_ctrl_fsm (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire wb_pkg::wb_req_t    wb_req,
  output wb_pkg::wb_rsp_t         wb_rsp,
  output rng_pkg::rng_cmd_t       cmd,
  input  wire rng_pkg::rng_byte_t rand_byte,
  output logic                    tmr_start,
  output logic [8:0]              tmr_count,
  input  wire logic               tmr_busy,
  input  wire logic               tmr_done
);

  import wb_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    STEP,
    RESP,
    WAIT_STB_LOW
  } state_t;

  state_t            state_q;
  state_t            state_d;
  wb_wdata_u         wdata;
  logic              strobe;
  logic              seed_wr;
  logic              ctrl_wr;
  logic              rand_rd;
  logic              count_rd;
  logic              rsp_err_q;
  logic [`WB_DW-1:0] rsp_dat_q;
  logic [15:0]       read_cnt_q;

  // Same bus word seen as a seed or as control fields
  assign wdata  = wb_req.dat;
  assign strobe = wb_req.cyc && wb_req.stb;

  // Register decode, a wrong direction counts as unmapped
  assign seed_wr  = (wb_req.adr == `RNG_ADDR_SEED)  &&  wb_req.we;
  assign ctrl_wr  = (wb_req.adr == `RNG_ADDR_CTRL)  &&  wb_req.we;
  assign rand_rd  = (wb_req.adr == `RNG_ADDR_RAND)  && !wb_req.we;
  assign count_rd = (wb_req.adr == `RNG_ADDR_COUNT) && !wb_req.we;

  always_comb begin
    state_d   = state_q;
    cmd       = '0;
    cmd.seed  = wdata.raw;
    tmr_start = 1'b0;
    tmr_count = '0;
    case (state_q)
      IDLE: begin
        if (strobe) begin
          if (seed_wr) begin
            // Load now, then prime both pipeline stages through the timer
            cmd.load  = 1'b1;
            tmr_start = 1'b1;
            tmr_count = 9'(`RNG_PRIME_STEPS);
            state_d   = STEP;
          end else if (ctrl_wr) begin
            tmr_start = 1'b1;
            tmr_count = {1'b0, wdata.ctrl.skip};
            state_d   = STEP;
          end else begin
            // A random read consumes the value it returns
            cmd.step = rand_rd;
            state_d  = RESP;
          end
        end
      end
      STEP: begin
        // One generator step per busy cycle of the timer
        cmd.step = tmr_busy;
        if (tmr_done) begin
          state_d = RESP;
        end
      end
      RESP: begin
        state_d = WAIT_STB_LOW;
      end
      WAIT_STB_LOW: begin
        // The master drops stb after the response before it starts again
        if (!wb_req.stb) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= IDLE;
      rsp_err_q  <= 1'b0;
      read_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if ((state_q == IDLE) && strobe) begin
        rsp_err_q <= !(seed_wr || ctrl_wr || rand_rd || count_rd);
        // Reads since the last seed, skips are not counted
        if (rand_rd) begin
          read_cnt_q <= read_cnt_q + 16'd1;
        end else if (seed_wr || (ctrl_wr && wdata.ctrl.clear_count)) begin
          read_cnt_q <= '0;
        end
      end
    end
  end

  // Read data is captured at decode, before the step of a random read lands
  always_ff @(posedge clk) begin
    if ((state_q == IDLE) && strobe) begin
      if (rand_rd) begin
        rsp_dat_q <= `WB_DW'(rand_byte);
      end else if (count_rd) begin
        rsp_dat_q <= `WB_DW'(read_cnt_q);
      end else begin
        rsp_dat_q <= '0;
      end
    end
  end

  // Response is held for the single RESP cycle
  always_comb begin
    wb_rsp.ack = (state_q == RESP) && !rsp_err_q;
    wb_rsp.err = (state_q == RESP) &&  rsp_err_q;
    wb_rsp.dat = rsp_dat_q;
  end

endmodule

`default_nettype wire

// File: rtl/rng_top.sv
// Random byte source top, Wishbone slave port joined to controller, step timer and generator
`timescale 1ns/10ps
`default_nettype none

module rng_top (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire wb_pkg::wb_req_t wb_req,
  output wb_pkg::wb_rsp_t      wb_rsp
);

  import rng_pkg::*;

  // Generator command and the byte it returns
  rng_cmd_t   cmd;
  rng_byte_t  rand_byte;

  // Owed step bookkeeping between the controller and the timer
  logic       tmr_start;
  logic [8:0] tmr_count;
  logic       tmr_busy;
  logic       tmr_done;

  // Bus decode and sequencing
  rng_ctrl_fsm ctrl_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .cmd       (cmd),
    .rand_byte (rand_byte),
    .tmr_start (tmr_start),
    .tmr_count (tmr_count),
    .tmr_busy  (tmr_busy),
    .tmr_done  (tmr_done)
  );

  // Counts the steps of a seed priming or a skip
  rng_step_timer timer_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .start (tmr_start),
    .count (tmr_count),
    .busy  (tmr_busy),
    .done  (tmr_done)
  );

  // Counter, hash and mixer, advanced only on command
  rng_hash_gen gen_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .rand_byte (rand_byte)
  );

endmodule

`default_nettype wire

// File: tb/rng_checker.sv
// Response checker that pairs each ack or err with the expectation queued by the bus master
`timescale 1ns/10ps
`default_nettype none

`include "rng_macros.svh"

module rng_checker (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire wb_pkg::wb_rsp_t wb_rsp,
  output int                   pass_cnt,
  output int                   fail_cnt
);

  // One expectation per transfer, kept in issue order
  typedef struct packed {
    logic              is_read;
    logic              exp_err;
    logic [`WB_DW-1:0] exp_dat;
    logic [15:0]       test_id;
    logic [15:0]       op_num;
  } expect_t;

  expect_t exp_q [$];

  // The master queues its expectation just before raising stb
  task automatic push_expect(input logic is_read, input logic exp_err,
                             input logic [`WB_DW-1:0] exp_dat,
                             input logic [15:0] test_id, input logic [15:0] op_num);
    expect_t e;
    e.is_read = is_read;
    e.exp_err = exp_err;
    e.exp_dat = exp_dat;
    e.test_id = test_id;
    e.op_num  = op_num;
    exp_q.push_back(e);
  endtask

  // Transfers still waiting for their response
  function automatic int outstanding();
    return exp_q.size();
  endfunction

  task automatic check_response();
    expect_t e;
    if (exp_q.size() == 0) begin
      $display("Response at %0d ns with no transfer outstanding", $time);
      fail_cnt++;
    end else begin
      e = exp_q.pop_front();
      if (wb_rsp.ack && wb_rsp.err) begin
        $display("Test %0d op %0d: ack and err were raised together", e.test_id, e.op_num);
        fail_cnt++;
      end else if (e.exp_err && wb_rsp.ack) begin
        $display("Test %0d op %0d: expected err but got ack", e.test_id, e.op_num);
        fail_cnt++;
      end else if (!e.exp_err && wb_rsp.err) begin
        $display("Test %0d op %0d: expected ack but got err", e.test_id, e.op_num);
        fail_cnt++;
      end else if (e.is_read && !e.exp_err && (wb_rsp.dat !== e.exp_dat)) begin
        $display("[FAIL] %0d ns wb_rsp.dat expected 0x%08h actual 0x%08h (test %0d op %0d)",
                 $time, e.exp_dat, wb_rsp.dat, e.test_id, e.op_num);
        fail_cnt++;
      end else begin
        $display("Test %0d op %0d: PASS", e.test_id, e.op_num);
        pass_cnt++;
      end
    end
  endtask

  // Responses change on the rising edge, so mid-cycle they are settled
  always @(negedge clk) begin
    if (!rst_n) begin
      pass_cnt = 0;
      fail_cnt = 0;
    end else if (wb_rsp.ack || wb_rsp.err) begin
      check_response();
    end
  end

endmodule

`default_nettype wire

// File: tb/tb_rng_top.sv
// Testbench top for the random byte source, file-driven Wishbone master with watchdog and summary
`timescale 1ns/10ps
`default_nettype none

`include "rng_macros.svh"

module tb_rng_top;

  import wb_pkg::*;

  // One operation as read from the test file
  typedef struct packed {
    logic              we;
    logic [`WB_AW-1:0] adr;
    logic [`WB_DW-1:0] dat;
    logic              exp_err;
    logic [15:0]       test_id;
  } test_op_t;

  logic     clk;
  logic     rst_n;
  wb_req_t  wb_req;
  wb_rsp_t  wb_rsp;
  int       pass_cnt;
  int       fail_cnt;
  test_op_t ops [$];
  int       cycles;
  int       cycle_limit;

  rng_top rng_top_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
  );

  // Compares every ack or err against the queued expectation
  rng_checker checker_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_rsp   (wb_rsp),
    .pass_cnt (pass_cnt),
    .fail_cnt (fail_cnt)
  );

  // 100 ns clock
  always #50 clk = ~clk;

  // Watchdog, the limit is only armed once the test file has been read
  always @(posedge clk) begin
    cycles = cycles + 1;
    if ((cycle_limit > 0) && (cycles >= cycle_limit)) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Done: errors found");
      $finish;
    end
  end

  // Reads every operation line, comment lines start with a hash
  task automatic load_tests(output bit ok);
    int          fd;
    int          n;
    int          skip_sum;
    string       line;
    logic [7:0]  op_c;
    logic [7:0]  rsp_c;
    logic [31:0] adr_v;
    logic [31:0] dat_v;
    int          id_v;
    test_op_t    op;
    ok = 1'b1;
    skip_sum = 0;
    fd = $fopen("tb/rng_tests.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the test file tb/rng_tests.txt");
      ok = 1'b0;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if ((n > 0) && (line[0] != "#")) begin
          n = $sscanf(line, "%s %h %h %s %d", op_c, adr_v, dat_v, rsp_c, id_v);
          if ((n == 5) && ((op_c == "W") || (op_c == "R")) &&
              ((rsp_c == "A") || (rsp_c == "E"))) begin
            op.we      = (op_c == "W");
            op.adr     = adr_v[`WB_AW-1:0];
            op.dat     = dat_v;
            op.exp_err = (rsp_c == "E");
            op.test_id = id_v[15:0];
            ops.push_back(op);
            // Skip commands own the longest stretches of steps
            if (op.we && (op.adr == `RNG_ADDR_CTRL)) begin
              skip_sum += int'(op.dat[7:0]);
            end
          end else if (n > 0) begin
            $display("Malformed line in the test file: %s", line);
            ok = 1'b0;
          end
        end
      end
      $fclose(fd);
    end
    cycle_limit = 20 * ops.size() + skip_sum + 100;
  endtask

  // Classic single transfer, request held until ack or err
  task automatic run_transfer(input test_op_t op, input int op_num);
    checker_inst.push_expect(!op.we, op.exp_err, op.dat, op.test_id, 16'(op_num));
    @(negedge clk);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = op.we;
    wb_req.adr = op.adr;
    wb_req.dat = op.we ? op.dat : '0;
    @(negedge clk);
    while (!(wb_rsp.ack || wb_rsp.err)) begin
      @(negedge clk);
    end
    wb_req = '0;
    // The slave must see stb low in its wait state before the next strobe
    @(negedge clk);
  endtask

  initial begin
    bit load_ok;
    int left;
    clk    = 1'b0;
    rst_n  = 1'b0;
    wb_req = '0;
    cycles = 0;
    cycle_limit = 0;
    load_tests(load_ok);
    if (load_ok) begin
      repeat (10) @(negedge clk);
      rst_n = 1'b1;
      foreach (ops[i]) begin
        run_transfer(ops[i], i + 1);
      end
    end
    left = checker_inst.outstanding();
    if (left != 0) begin
      $display("%0d transfers never got a response", left);
    end
    $display("Summary: %0d passed, %0d failed, %0d operations", pass_cnt, fail_cnt, ops.size());
    if (load_ok && (ops.size() > 0) && (fail_cnt == 0) && (left == 0) &&
        (pass_cnt == ops.size())) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/rng_tests.txt
# op addr data resp test: op is W or R, addr and data in hex, resp is A for ack or E for err
# On an acked read the data column holds the expected value, v(c) is mix(crc(c)) of counter c
# Test 1, seed 1 then v(1) to v(8)
W 0 00000001 A 1
R 2 00000098 A 1
R 2 00000035 A 1
R 2 000000F8 A 1
R 2 00000090 A 1
R 2 0000005D A 1
R 2 000000A5 A 1
R 2 0000003D A 1
R 2 00000075 A 1
# Test 2, reseed restarts at v(12345678) then v(12345679)
W 0 12345678 A 2
R 2 00000090 A 2
R 2 0000005D A 2
# Test 3, three reads then skip 5 lands on v(9)
W 0 00000001 A 3
R 2 00000098 A 3
R 2 00000035 A 3
R 2 000000F8 A 3
W 1 00000005 A 3
R 2 000000B8 A 3
# Test 4, read count and clear with skip 0, sequence continues at v(10)
R 3 00000004 A 4
W 1 00000100 A 4
R 3 00000000 A 4
R 2 0000000A A 4
R 3 00000001 A 4
# Test 5, bad accesses answer err and leave the sequence at v(11)
W 2 00000000 E 5
R 0 00000000 E 5
R 5 00000000 E 5
W F 00000000 E 5
R 2 0000002D A 5
R 3 00000002 A 5

// File: vlog.f
+incdir+include
rtl/rng_pkg.sv
rtl/wb_pkg.sv
rtl/rng_hash_gen.sv
rtl/rng_step_timer.sv
rtl/rng_ctrl_fsm.sv
rtl/rng_top.sv
tb/rng_checker.sv
tb/tb_rng_top.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the summary line
cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module tb_rng_top -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_rng_top)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Done: no errors"; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed"
exit 1
